//--- common/uart_axil_pkg.sv
`default_nettype none

package uart_axil_pkg;

    // Frame format and timebase
    localparam int DATA_BITS     = 8;  // LSB first
    localparam int STOP_BITS     = 2;
    localparam int OVERSAMPLE    = 16;
    localparam int CLKS_PER_TICK = 4;  // 64 cycles per bit

    typedef logic [DATA_BITS-1:0]          data_t;
    typedef logic [3:0]                    axil_addr_t;
    typedef logic [31:0]                   axil_data_t;
    typedef logic [$clog2(OVERSAMPLE)-1:0] tick_cnt_t;
    typedef logic [2:0]                    bit_cnt_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    // Register map
    localparam axil_addr_t REG_TXDATA = 4'h0;
    localparam axil_addr_t REG_RXDATA = 4'h4;
    localparam axil_addr_t REG_STATUS = 4'h8;

    // STATUS bit positions
    localparam int STAT_RX_VALID  = 0;
    localparam int STAT_TX_BUSY   = 1;
    localparam int STAT_OVERRUN   = 2;
    localparam int STAT_FRAME_ERR = 3;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- serial/baud_tick_gen.sv
`default_nettype none

module baud_tick_gen (
    input  logic i_rate,
    input  logic i_reset,
    output logic o_tick
);

    import uart_axil_pkg::*;

    logic [$clog2(CLKS_PER_TICK)-1:0] div_cnt;

    // Down-counter, one tick per wrap
    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            div_cnt <= ($clog2(CLKS_PER_TICK))'(CLKS_PER_TICK - 1);
            o_tick  <= 1'b0;
        end else begin
            if (div_cnt == '0) begin
                div_cnt <= ($clog2(CLKS_PER_TICK))'(CLKS_PER_TICK - 1);
                o_tick  <= 1'b1;
            end else begin
                div_cnt <= div_cnt - 1'b1;
                o_tick  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- serial/uart_rx.sv
`default_nettype none

module uart_rx (
    input  logic                i_rate,
    input  logic                i_reset,
    input  logic                i_tick,
    input  logic                i_rx,
    output logic                o_rx_valid,
    output logic                o_rx_frame_err,
    output uart_axil_pkg::data_t o_rx_data
);

    import uart_axil_pkg::*;

    rx_state_t state;
    tick_cnt_t tick_cnt;
    bit_cnt_t  bit_cnt;
    data_t     shift_q;
    logic      rx_meta;
    logic      rx_sync;
    logic      stop_ok;  // All stop bits high so far

    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            state          <= RX_IDLE;
            tick_cnt       <= '0;
            bit_cnt        <= '0;
            stop_ok        <= 1'b1;
            o_rx_valid     <= 1'b0;
            o_rx_frame_err <= 1'b0;
        end else begin
            o_rx_valid     <= 1'b0;
            o_rx_frame_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    if (!rx_sync) state <= RX_START;
                end
                RX_START: if (i_tick) begin
                    if (tick_cnt == tick_cnt_t'(OVERSAMPLE / 2 - 1)) begin
                        tick_cnt <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA;  // High again is a glitch
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1)) begin
                        shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
                        if (bit_cnt == bit_cnt_t'(DATA_BITS - 1)) begin
                            bit_cnt <= '0;
                            stop_ok <= 1'b1;
                            state   <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_STOP: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1)) begin
                        if (bit_cnt == bit_cnt_t'(STOP_BITS - 1)) begin
                            state <= RX_IDLE;
                            if (stop_ok && rx_sync) o_rx_valid <= 1'b1;
                            else                    o_rx_frame_err <= 1'b1;
                        end else begin
                            stop_ok <= stop_ok & rx_sync;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Shift register alone holds the byte
    assign o_rx_data = shift_q;

endmodule

`default_nettype wire

//--- serial/uart_tx.sv
`default_nettype none

module uart_tx (
    input  logic                 i_rate,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  logic                 i_tx_start,
    input  uart_axil_pkg::data_t i_tx_data,
    output logic                 o_tx,
    output logic                 o_tx_busy
);

    import uart_axil_pkg::*;

    tx_state_t state;
    tick_cnt_t tick_cnt;
    bit_cnt_t  bit_cnt;
    data_t     shift_q;

    // Each bit is driven on phase 0 and ends after phase 15
    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            state     <= TX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_tx      <= 1'b1;
            o_tx_busy <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    o_tx     <= 1'b1;
                    if (i_tx_start) begin
                        o_tx_busy <= 1'b1;
                        state     <= TX_START;
                    end
                end
                TX_START: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == '0) o_tx <= 1'b0;
                    if (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1)) state <= TX_DATA;
                end
                TX_DATA: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == '0) o_tx <= shift_q[0];  // LSB first
                    if (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1)) begin
                        if (bit_cnt == bit_cnt_t'(DATA_BITS - 1)) begin
                            bit_cnt <= '0;
                            state   <= TX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_STOP: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == '0) o_tx <= 1'b1;
                    if (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1)) begin
                        if (bit_cnt == bit_cnt_t'(STOP_BITS - 1)) begin
                            o_tx_busy <= 1'b0;
                            state     <= TX_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_rate) begin
        if (state == TX_IDLE && i_tx_start) begin
            shift_q <= i_tx_data;
        end else if (state == TX_DATA && i_tick && tick_cnt == tick_cnt_t'(OVERSAMPLE - 1)) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_axil_regs.sv
`default_nettype none

module uart_axil_regs (
    input  logic                      i_rate,
    input  logic                      i_reset,
    input  logic                      i_s_axil_awvalid,
    input  uart_axil_pkg::axil_addr_t i_s_axil_awaddr,
    input  logic                      i_s_axil_wvalid,
    input  uart_axil_pkg::axil_data_t i_s_axil_wdata,
    input  logic                      i_s_axil_bready,
    input  logic                      i_s_axil_arvalid,
    input  uart_axil_pkg::axil_addr_t i_s_axil_araddr,
    input  logic                      i_s_axil_rready,
    output logic                      o_s_axil_awready,
    output logic                      o_s_axil_wready,
    output logic                      o_s_axil_bvalid,
    output logic [1:0]                o_s_axil_bresp,
    output logic                      o_s_axil_arready,
    output logic                      o_s_axil_rvalid,
    output uart_axil_pkg::axil_data_t o_s_axil_rdata,
    output logic [1:0]                o_s_axil_rresp,
    input  logic                      i_rx_valid,
    input  logic                      i_rx_frame_err,
    input  uart_axil_pkg::data_t      i_rx_data,
    input  logic                      i_tx_busy,
    output logic                      o_tx_start,
    output uart_axil_pkg::data_t      o_tx_data
);

    import uart_axil_pkg::*;

    logic       wr_txdata;
    logic       wr_addr_ok;
    logic       wr_accept;
    logic       rd_accept;
    logic       rd_rxdata;
    logic       rd_status;
    logic       rd_addr_ok;
    logic       rx_valid_q;
    logic       overrun_q;
    logic       frame_err_q;
    data_t      rx_data_q;
    axil_data_t status_word;
    axil_data_t rd_word;

    // Write side, TXDATA stalls while the transmitter is busy
    assign wr_txdata  = (i_s_axil_awaddr == REG_TXDATA);
    assign wr_addr_ok = wr_txdata || i_s_axil_awaddr == REG_RXDATA
                        || i_s_axil_awaddr == REG_STATUS;
    assign wr_accept  = i_s_axil_awvalid && i_s_axil_wvalid && !o_s_axil_bvalid
                        && !(wr_txdata && i_tx_busy);
    assign o_s_axil_awready = wr_accept;
    assign o_s_axil_wready  = wr_accept;
    assign o_tx_start       = wr_accept && wr_txdata;
    assign o_tx_data        = i_s_axil_wdata[DATA_BITS-1:0];

    assign rd_accept        = i_s_axil_arvalid && !o_s_axil_rvalid;
    assign o_s_axil_arready = rd_accept;
    assign rd_rxdata        = rd_accept && i_s_axil_araddr == REG_RXDATA;
    assign rd_status        = rd_accept && i_s_axil_araddr == REG_STATUS;

    always_comb begin
        status_word                 = '0;
        status_word[STAT_RX_VALID]  = rx_valid_q;
        status_word[STAT_TX_BUSY]   = i_tx_busy;
        status_word[STAT_OVERRUN]   = overrun_q;
        status_word[STAT_FRAME_ERR] = frame_err_q;
    end

    always_comb begin
        rd_addr_ok = 1'b1;
        case (i_s_axil_araddr)
            REG_TXDATA: rd_word = '0;  // Write only
            REG_RXDATA: rd_word = axil_data_t'(rx_data_q);
            REG_STATUS: rd_word = status_word;
            default: begin
                rd_word    = '0;
                rd_addr_ok = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            o_s_axil_bvalid <= 1'b0;
            o_s_axil_rvalid <= 1'b0;
        end else begin
            if (wr_accept)            o_s_axil_bvalid <= 1'b1;
            else if (i_s_axil_bready) o_s_axil_bvalid <= 1'b0;
            if (rd_accept)            o_s_axil_rvalid <= 1'b1;
            else if (i_s_axil_rready) o_s_axil_rvalid <= 1'b0;
        end
    end

    // Response payload, held until the next accept
    always_ff @(posedge i_rate) begin
        if (wr_accept) o_s_axil_bresp <= wr_addr_ok ? RESP_OKAY : RESP_SLVERR;
        if (rd_accept) begin
            o_s_axil_rdata <= rd_word;
            o_s_axil_rresp <= rd_addr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (i_rx_valid) rx_data_q <= i_rx_data;  // Newest byte wins
    end

    // Sticky status, a new event beats a clearing read
    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            rx_valid_q  <= 1'b0;
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            if (i_rx_valid)     rx_valid_q <= 1'b1;
            else if (rd_rxdata) rx_valid_q <= 1'b0;

            if (i_rx_valid && rx_valid_q && !rd_rxdata) overrun_q <= 1'b1;
            else if (rd_status)                         overrun_q <= 1'b0;

            if (i_rx_frame_err) frame_err_q <= 1'b1;
            else if (rd_status) frame_err_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_axil_top.sv
`default_nettype none

module uart_axil_top (
    input  logic                      i_rate,
    input  logic                      i_reset,
    input  logic                      i_s_axil_awvalid,
    input  uart_axil_pkg::axil_addr_t i_s_axil_awaddr,
    input  logic                      i_s_axil_wvalid,
    input  uart_axil_pkg::axil_data_t i_s_axil_wdata,
    input  logic                      i_s_axil_bready,
    input  logic                      i_s_axil_arvalid,
    input  uart_axil_pkg::axil_addr_t i_s_axil_araddr,
    input  logic                      i_s_axil_rready,
    output logic                      o_s_axil_awready,
    output logic                      o_s_axil_wready,
    output logic                      o_s_axil_bvalid,
    output logic [1:0]                o_s_axil_bresp,
    output logic                      o_s_axil_arready,
    output logic                      o_s_axil_rvalid,
    output uart_axil_pkg::axil_data_t o_s_axil_rdata,
    output logic [1:0]                o_s_axil_rresp,
    input  logic                      i_rx,
    output logic                      o_tx
);

    import uart_axil_pkg::*;

    logic  tick;  // Shared 16x timebase
    logic  rx_valid;
    logic  rx_frame_err;
    logic  tx_start;
    logic  tx_busy;
    data_t rx_data;
    data_t tx_data;

    baud_tick_gen u_baud_tick_gen (
        .i_rate  (i_rate),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx u_uart_rx (
        .i_rate         (i_rate),
        .i_reset        (i_reset),
        .i_tick         (tick),
        .i_rx           (i_rx),
        .o_rx_valid     (rx_valid),
        .o_rx_frame_err (rx_frame_err),
        .o_rx_data      (rx_data)
    );

    uart_tx u_uart_tx (
        .i_rate     (i_rate),
        .i_reset    (i_reset),
        .i_tick     (tick),
        .i_tx_start (tx_start),
        .i_tx_data  (tx_data),
        .o_tx       (o_tx),
        .o_tx_busy  (tx_busy)
    );

    uart_axil_regs u_uart_axil_regs (
        .i_rate           (i_rate),
        .i_reset          (i_reset),
        .i_s_axil_awvalid (i_s_axil_awvalid),
        .i_s_axil_awaddr  (i_s_axil_awaddr),
        .i_s_axil_wvalid  (i_s_axil_wvalid),
        .i_s_axil_wdata   (i_s_axil_wdata),
        .i_s_axil_bready  (i_s_axil_bready),
        .i_s_axil_arvalid (i_s_axil_arvalid),
        .i_s_axil_araddr  (i_s_axil_araddr),
        .i_s_axil_rready  (i_s_axil_rready),
        .o_s_axil_awready (o_s_axil_awready),
        .o_s_axil_wready  (o_s_axil_wready),
        .o_s_axil_bvalid  (o_s_axil_bvalid),
        .o_s_axil_bresp   (o_s_axil_bresp),
        .o_s_axil_arready (o_s_axil_arready),
        .o_s_axil_rvalid  (o_s_axil_rvalid),
        .o_s_axil_rdata   (o_s_axil_rdata),
        .o_s_axil_rresp   (o_s_axil_rresp),
        .i_rx_valid       (rx_valid),
        .i_rx_frame_err   (rx_frame_err),
        .i_rx_data        (rx_data),
        .i_tx_busy        (tx_busy),
        .o_tx_start       (tx_start),
        .o_tx_data        (tx_data)
    );

endmodule

`default_nettype wire

//--- bench/uart_axil_chk.sv
`default_nettype none

module uart_axil_chk (
    input logic                      i_rate,
    input logic                      i_reset,
    input logic                      i_bvalid,
    input logic                      i_bready,
    input logic                      i_rvalid,
    input logic                      i_rready,
    input uart_axil_pkg::axil_data_t i_rdata,
    input logic                      i_tx,
    input logic                      i_tx_busy
);

    int fails = 0;

    bvalid_hold: assert property (@(posedge i_rate) disable iff (!i_reset)
        i_bvalid && !i_bready |=> i_bvalid)
        else begin
            $error("BVALID dropped before BREADY");
            fails++;
        end

    rvalid_hold: assert property (@(posedge i_rate) disable iff (!i_reset)
        i_rvalid && !i_rready |=> i_rvalid)
        else begin
            $error("RVALID dropped before RREADY");
            fails++;
        end

    // Read data frozen while the host stalls
    rdata_stable: assert property (@(posedge i_rate) disable iff (!i_reset)
        i_rvalid && !i_rready |=> $stable(i_rdata))
        else begin
            $error("RDATA changed while waiting for RREADY");
            fails++;
        end

    tx_idle_high: assert property (@(posedge i_rate) disable iff (!i_reset)
        !i_tx_busy |-> i_tx)
        else begin
            $error("o_tx low while the transmitter is idle");
            fails++;
        end

endmodule

`default_nettype wire

//--- bench/uart_axil_tb.sv
`default_nettype none

module uart_axil_tb;

    import uart_axil_pkg::*;

    localparam int FRAMES     = 20;  // Frames sent or received over all tests
    localparam int FRAME_CLKS = 704;
    localparam int BIT_CLKS   = 64;

    logic        i_rate;
    logic        i_reset;
    logic        i_s_axil_awvalid, i_s_axil_wvalid, i_s_axil_bready;
    logic        i_s_axil_arvalid, i_s_axil_rready, i_rx;
    axil_addr_t  i_s_axil_awaddr, i_s_axil_araddr;
    axil_data_t  i_s_axil_wdata;
    logic        o_s_axil_awready, o_s_axil_wready, o_s_axil_bvalid;
    logic        o_s_axil_arready, o_s_axil_rvalid, o_tx;
    logic [1:0]  o_s_axil_bresp, o_s_axil_rresp;
    axil_data_t  o_s_axil_rdata;

    logic [31:0] rng_state = 32'hd7d0;
    int          checks, errors, tests, test_errors;
    logic        m_rx_valid, m_overrun, m_frame_err;  // Expected status bits
    data_t       m_rx_byte;
    data_t       tx_exp[$];
    data_t       tx_seen[$];

    uart_axil_top u_uart_axil_top (.*);

    bind uart_axil_top uart_axil_chk u_uart_axil_chk (
        .i_rate    (i_rate),
        .i_reset   (i_reset),
        .i_bvalid  (o_s_axil_bvalid),
        .i_bready  (i_s_axil_bready),
        .i_rvalid  (o_s_axil_rvalid),
        .i_rready  (i_s_axil_rready),
        .i_rdata   (o_s_axil_rdata),
        .i_tx      (o_tx),
        .i_tx_busy (tx_busy)
    );

    initial begin
        i_rate = 1'b0;
        forever #5 i_rate = ~i_rate;
    end

    initial begin
        repeat (FRAMES * FRAME_CLKS * 3) @(posedge i_rate);
        $display("Timeout after %0d cycles, a test stalled", FRAMES * FRAME_CLKS * 3);
        $display("Simulation failed");
        $finish;
    end

    // Serial monitor on o_tx
    initial begin : tx_monitor
        data_t b;
        forever begin
            @(negedge i_rate);
            if (o_tx === 1'b0) begin
                repeat (BIT_CLKS / 2) @(negedge i_rate);  // Middle of start bit
                for (int i = 0; i < DATA_BITS; i++) begin
                    repeat (BIT_CLKS) @(negedge i_rate);
                    b[i] = o_tx;
                end
                for (int i = 0; i < STOP_BITS; i++) begin
                    repeat (BIT_CLKS) @(negedge i_rate);
                    check_eq("stop bit", o_tx, 1);
                end
                tx_seen.push_back(b);
            end
        end
    end

    function automatic data_t random_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    function automatic axil_data_t expected_status(input logic tx_busy);
        axil_data_t w;
        w                 = '0;
        w[STAT_RX_VALID]  = m_rx_valid;
        w[STAT_TX_BUSY]   = tx_busy;
        w[STAT_OVERRUN]   = m_overrun;
        w[STAT_FRAME_ERR] = m_frame_err;
        return w;
    endfunction

    task automatic check_eq(input string what, input axil_data_t got, input axil_data_t want);
        checks++;
        assert (got === want) else begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s %s, %0d errors", name,
                 (errors == test_errors) ? "ok" : "FAILED", errors - test_errors);
        test_errors = errors;
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input logic [1:0] want_resp);
        @(posedge i_rate);
        i_s_axil_awvalid <= 1'b1;
        i_s_axil_awaddr  <= addr;
        i_s_axil_wvalid  <= 1'b1;
        i_s_axil_wdata   <= data;
        do @(negedge i_rate); while (!o_s_axil_awready);  // Stalls while tx busy
        check_eq("WREADY with AWREADY", o_s_axil_wready, 1);
        @(posedge i_rate);
        i_s_axil_awvalid <= 1'b0;
        i_s_axil_wvalid  <= 1'b0;
        do @(negedge i_rate); while (!o_s_axil_bvalid);
        check_eq("write response", o_s_axil_bresp, want_resp);
        @(posedge i_rate);
        i_s_axil_bready <= 1'b1;
        @(posedge i_rate);
        i_s_axil_bready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, input logic [1:0] want_resp,
                             output axil_data_t data);
        @(posedge i_rate);
        i_s_axil_arvalid <= 1'b1;
        i_s_axil_araddr  <= addr;
        do @(negedge i_rate); while (!o_s_axil_arready);
        @(posedge i_rate);
        i_s_axil_arvalid <= 1'b0;
        do @(negedge i_rate); while (!o_s_axil_rvalid);
        data = o_s_axil_rdata;
        check_eq("read response", o_s_axil_rresp, want_resp);
        @(posedge i_rate);
        i_s_axil_rready <= 1'b1;  // RVALID waits one cycle first
        @(posedge i_rate);
        i_s_axil_rready <= 1'b0;
    endtask

    // Reads STATUS until the chosen bit matches the model or the poll limit is hit
    task automatic read_status(input logic tx_busy, input int bit_pos, input int max_polls);
        axil_data_t want;
        axil_data_t data;
        int         polls;
        want  = expected_status(tx_busy);
        polls = 0;
        do begin
            axil_read(REG_STATUS, RESP_OKAY, data);
            polls++;
        end while (data[bit_pos] !== want[bit_pos] && polls < max_polls);
        check_eq("STATUS", data, want);
        m_overrun   = 1'b0;
        m_frame_err = 1'b0;
    endtask

    task automatic read_rxdata();
        axil_data_t data;
        axil_read(REG_RXDATA, RESP_OKAY, data);
        check_eq("RXDATA", data, axil_data_t'(m_rx_byte));
        m_rx_valid = 1'b0;
    endtask

    task automatic send_frame(input data_t b, input logic bad_stop);
        logic [10:0] frame;
        frame = {1'b1, ~bad_stop, b, 1'b0};  // Stop bits, data LSB first, start
        for (int i = 0; i < 11; i++) begin
            @(posedge i_rate);
            i_rx <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge i_rate);
        end
        if (bad_stop) begin
            m_frame_err = 1'b1;
        end else begin
            m_overrun  = m_overrun | m_rx_valid;
            m_rx_valid = 1'b1;
            m_rx_byte  = b;
        end
    endtask

    initial begin
        data_t      b;
        axil_data_t data;
        i_reset          = 1'b0;
        i_s_axil_awvalid = 1'b0;
        i_s_axil_awaddr  = '0;
        i_s_axil_wvalid  = 1'b0;
        i_s_axil_wdata   = '0;
        i_s_axil_bready  = 1'b0;
        i_s_axil_arvalid = 1'b0;
        i_s_axil_araddr  = '0;
        i_s_axil_rready  = 1'b0;
        i_rx             = 1'b1;  // Line idles high
        m_rx_valid       = 1'b0;
        m_overrun        = 1'b0;
        m_frame_err      = 1'b0;
        m_rx_byte        = '0;
        repeat (3) @(posedge i_rate);
        i_reset <= 1'b1;

        @(negedge i_rate);
        check_eq("o_tx after reset", o_tx, 1);
        check_eq("BVALID after reset", o_s_axil_bvalid, 0);
        check_eq("RVALID after reset", o_s_axil_rvalid, 0);
        read_status(1'b0, STAT_RX_VALID, 1);
        end_test("reset");

        for (int i = 0; i < 8; i++) begin
            b = random_byte();
            tx_exp.push_back(b);
            axil_write(REG_TXDATA, axil_data_t'(b), RESP_OKAY);
            read_status(1'b1, STAT_TX_BUSY, 1);
        end
        while (tx_seen.size() < 8) @(posedge i_rate);
        read_status(1'b0, STAT_TX_BUSY, 200);
        check_eq("transmitted count", tx_seen.size(), 8);
        foreach (tx_exp[i]) check_eq("transmitted byte", tx_seen[i], tx_exp[i]);
        end_test("transmit");

        for (int i = 0; i < 8; i++) begin
            send_frame(random_byte(), 1'b0);
            read_status(1'b0, STAT_RX_VALID, 50);
            read_rxdata();
            read_status(1'b0, STAT_RX_VALID, 1);
        end
        end_test("receive");

        send_frame(random_byte(), 1'b0);
        send_frame(random_byte(), 1'b0);
        read_status(1'b0, STAT_OVERRUN, 50);
        read_rxdata();
        read_status(1'b0, STAT_OVERRUN, 1);
        end_test("overrun");

        send_frame(random_byte(), 1'b1);
        read_status(1'b0, STAT_FRAME_ERR, 50);
        read_status(1'b0, STAT_FRAME_ERR, 1);
        end_test("framing");

        send_frame(random_byte(), 1'b0);
        axil_read(4'hC, RESP_SLVERR, data);
        axil_write(4'hC, 32'h5a, RESP_SLVERR);
        axil_write(REG_RXDATA, ~axil_data_t'(m_rx_byte), RESP_OKAY);  // Ignored
        read_status(1'b0, STAT_RX_VALID, 50);
        read_rxdata();
        end_test("address");

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
                 errors, u_uart_axil_top.u_uart_axil_chk.fails);
        if (errors == 0 && u_uart_axil_top.u_uart_axil_chk.fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_axil.f
common/uart_axil_pkg.sv
serial/baud_tick_gen.sv
serial/uart_rx.sv
serial/uart_tx.sv
rtl/uart_axil_regs.sv
rtl/uart_axil_top.sv
bench/uart_axil_chk.sv
bench/uart_axil_tb.sv
